// File: hw/gb_cart_pkg.sv
package gb_cart_pkg;

	// ----------------------------------------------------------
	// bus widths
	// ----------------------------------------------------------

	typedef logic [15:0] cpu_addr_t;      // cpu cartridge address
	typedef logic [7:0]  cpu_data_t;      // cpu data byte
	typedef logic [24:0] dl_addr_t;       // download byte address
	typedef logic [15:0] dl_data_t;       // odd byte sits in [15:8]

	// bank numbers
	typedef logic [8:0]  rom_bank_t;      // up to 512 banks on mbc5
	typedef logic [3:0]  ram_bank_t;      // up to 16 banks of 8k

	typedef logic [21:0] rom_word_addr_t; // sdram word address
	typedef logic [16:0] cram_addr_t;     // 128k of cartridge ram

	// controller kind decoded from header byte 0x147
	typedef enum logic [2:0] {
		MBC_NONE,
		MBC_1,
		MBC_2,
		MBC_3,
		MBC_5
	} mbc_kind_t;

	// ----------------------------------------------------------
	// cartridge header locations, on the download bus
	// ----------------------------------------------------------

	localparam dl_addr_t HDR_CGB_ADDR  = 25'h000142; // colour flag in upper byte
	localparam dl_addr_t HDR_TYPE_ADDR = 25'h000146; // cart type in upper byte
	localparam dl_addr_t HDR_SIZE_ADDR = 25'h000148; // {ram size, rom size}

	// ----------------------------------------------------------
	// cpu address regions
	// ----------------------------------------------------------

	// decoded on cart_addr[15:14]
	localparam logic [1:0] ROM_BANK0_AREA = 2'b00; // 0000-3fff fixed bank
	localparam logic [1:0] ROM_BANKN_AREA = 2'b01; // 4000-7fff switchable

	// register writes, decoded on cart_addr[15:13]
	localparam logic [2:0] REG_RAM_EN   = 3'b000; // 0000-1fff
	localparam logic [2:0] REG_ROM_BANK = 3'b001; // 2000-3fff
	localparam logic [2:0] REG_RAM_BANK = 3'b010; // 4000-5fff
	localparam logic [2:0] REG_MODE     = 3'b011; // 6000-7fff

	localparam logic [2:0] CRAM_REGION  = 3'b101; // a000-bfff ram window

	// mbc2 has 512 nibbles, a000-a1ff on cart_addr[15:9]
	localparam logic [6:0] MBC2_RAM_WIN = 7'b1010000;

	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA; // low nibble that opens ram

	localparam int CRAM_DEPTH = 2 ** $bits(cram_addr_t);

endpackage

// File: hw/mbc_bank_if.sv
`timescale 1ns/1ps

// bank register state, from the register block to the address map
interface mbc_bank_if;
	import gb_cart_pkg::*;

	rom_bank_t rom_bank;   // selected rom bank for 4000-7fff
	ram_bank_t ram_bank;   // selected ram bank, also upper rom bits on mbc1
	logic      mbc1_mode;  // 0 = 16/8 mode, 1 = 4/32 mode
	logic      rtc_mode;   // mbc3 clock registers mapped at a000
	logic      ram_enable;

	modport regs (
		output rom_bank, ram_bank, mbc1_mode, rtc_mode, ram_enable
	);

	modport map (
		input rom_bank, ram_bank, mbc1_mode, rtc_mode, ram_enable
	);

endinterface

// File: hw/cart_header_capture.sv
`timescale 1ns/1ps

module cart_header_capture (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active_i,  // rom image download running
	input  logic                   dl_wr_i,
	input  gb_cart_pkg::dl_addr_t  dl_addr_i,
	input  gb_cart_pkg::dl_data_t  dl_data_i,
	output gb_cart_pkg::mbc_kind_t kind_o,
	output gb_cart_pkg::rom_bank_t rom_mask_o,
	output gb_cart_pkg::ram_bank_t ram_mask_o,
	output logic                   cgb_game_o
);
	import gb_cart_pkg::*;

	cpu_data_t cgb_flag;   // header 0x143 byte
	cpu_data_t cart_type;  // header 0x147
	cpu_data_t rom_size;   // header 0x148
	cpu_data_t ram_size;   // header 0x149

	// ----------------------------------------------------------
	// header capture, words arrive on even addresses
	// ----------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cgb_flag  <= '0;
			cart_type <= '0;
			rom_size  <= '0;
			ram_size  <= '0;
		end else if (dl_active_i && dl_wr_i) begin
			case (dl_addr_i)
				HDR_CGB_ADDR:  cgb_flag  <= dl_data_i[15:8];
				HDR_TYPE_ADDR: cart_type <= dl_data_i[15:8];
				HDR_SIZE_ADDR: {ram_size, rom_size} <= dl_data_i;
				default: ;
			endcase
		end
	end

	// controller kind from the cart type byte
	always_comb begin
		if (cart_type inside {[8'h01:8'h03]}) begin
			kind_o = MBC_1;
		end else if (cart_type inside {[8'h05:8'h06]}) begin
			kind_o = MBC_2;
		end else if (cart_type inside {[8'h0F:8'h13]}) begin
			kind_o = MBC_3;
		end else if (cart_type inside {[8'h19:8'h1E]}) begin
			kind_o = MBC_5;
		end else begin
			kind_o = MBC_NONE;  // plain 32k rom, or a mapper we do not handle
		end
	end

	// rom size n -> 2^(n+1) banks, odd sizes fall back to 128 banks
	always_comb begin
		if (rom_size inside {[8'd1:8'd8]}) begin
			rom_mask_o = rom_bank_t'((10'd2 << rom_size[3:0]) - 10'd1);
		end else begin
			rom_mask_o = rom_bank_t'(127);
		end
	end

	// 0-2 is a single bank or less, 3 is 32k, larger is 128k
	assign ram_mask_o = (ram_size <= 8'd2) ? 4'h0 :
	                    (ram_size == 8'd3) ? 4'h3 : 4'hF;

	assign cgb_game_o = (cgb_flag == 8'h80) || (cgb_flag == 8'hC0); // dual mode or cgb only

endmodule

// File: hw/mbc_bank_regs.sv
`timescale 1ns/1ps

module mbc_bank_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active_i,  // hold regs while a rom loads
	input  logic                   cart_wr_i,
	input  gb_cart_pkg::cpu_addr_t cart_addr_i,
	input  gb_cart_pkg::cpu_data_t cart_di_i,
	input  gb_cart_pkg::mbc_kind_t kind_i,
	mbc_bank_if.regs               bank
);
	import gb_cart_pkg::*;

	logic [2:0] wr_region;  // 8k region of the write

	assign wr_region = cart_addr_i[15:13];

	// ----------------------------------------------------------
	// cpu writes into the rom area land here
	// ----------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active_i) begin
			bank.rom_bank   <= rom_bank_t'(1);  // bank 1 mapped at 4000 out of reset
			bank.ram_bank   <= '0;
			bank.mbc1_mode  <= 1'b0;
			bank.rtc_mode   <= 1'b0;
			bank.ram_enable <= 1'b0;
		end else if (cart_wr_i) begin
			case (wr_region)
				REG_RAM_EN: begin
					bank.ram_enable <= (cart_di_i[3:0] == RAM_ENABLE_KEY);
				end

				REG_ROM_BANK: begin
					if (kind_i == MBC_5) begin
						// mbc5 splits the 9 bit bank over two registers
						if (cart_addr_i[12]) begin
							bank.rom_bank[8] <= cart_di_i[0];  // 3000-3fff
						end else begin
							bank.rom_bank[7:0] <= cart_di_i;  // 2000-2fff
						end
					end else if (cart_di_i[6:0] == 7'd0) begin
						bank.rom_bank <= rom_bank_t'(1);  // bank 0 reads as bank 1
					end else begin
						bank.rom_bank <= {2'b00, cart_di_i[6:0]};
					end
				end

				REG_RAM_BANK: begin
					if (kind_i == MBC_3) begin
						if (cart_di_i[3]) begin
							bank.rtc_mode <= 1'b1;  // 08-0c select a clock register
						end else begin
							bank.rtc_mode <= 1'b0;
							bank.ram_bank <= {2'b00, cart_di_i[1:0]};
						end
					end else if (kind_i == MBC_5) begin
						bank.ram_bank <= cart_di_i[3:0];
					end else begin
						bank.ram_bank <= {2'b00, cart_di_i[1:0]};  // mbc1 upper bits
					end
				end

				REG_MODE: begin
					if (kind_i == MBC_1) begin
						bank.mbc1_mode <= cart_di_i[0];
					end
				end

				default: ;  // ram window and above, not a register
			endcase
		end
	end

endmodule

// File: hw/cart_ram.sv
`timescale 1ns/1ps

// ----------------------------------------------------------
// cartridge ram, one byte per address
// ----------------------------------------------------------
module cart_ram (
	input  logic                    clk_sys,
	input  logic                    we_i,
	input  gb_cart_pkg::cram_addr_t addr_i,
	input  gb_cart_pkg::cpu_data_t  wdata_i,
	output gb_cart_pkg::cpu_data_t  rdata_o
);
	import gb_cart_pkg::*;

	cpu_data_t mem [CRAM_DEPTH];  // 16 banks of 8k

	// single port, read gives the old byte on a write to the same address
	always_ff @(posedge clk_sys) begin
		if (we_i) begin
			mem[addr_i] <= wdata_i;
		end
		rdata_o <= mem[addr_i];  // one cycle read latency
	end

endmodule

// File: hw/cart_addr_map.sv
`timescale 1ns/1ps

module cart_addr_map (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        cart_rd_i,
	input  logic                        cart_wr_i,
	input  gb_cart_pkg::cpu_addr_t      cart_addr_i,
	input  gb_cart_pkg::cpu_data_t      cart_di_i,
	input  gb_cart_pkg::mbc_kind_t      kind_i,
	input  gb_cart_pkg::rom_bank_t      rom_mask_i,
	input  gb_cart_pkg::ram_bank_t      ram_mask_i,
	mbc_bank_if.map                     bank,
	output gb_cart_pkg::rom_word_addr_t rom_addr_o,
	output gb_cart_pkg::cpu_data_t      cart_do_o,
	output logic                        cram_valid_o
);
	import gb_cart_pkg::*;

	rom_bank_t  masked_bank;   // bank after mirroring
	logic [9:0] bank_field;    // 16k bank plus a13, the upper word address bits
	ram_bank_t  ram_bank_sel;
	cram_addr_t cram_addr;
	logic       cram_sel;
	logic       mbc2_win;
	cpu_data_t  ram_q;
	logic       rd_en_q;       // read qualifiers, aligned with ram_q
	logic       rd_mbc2_q;
	logic       rd_rtc_q;

	// ----------------------------------------------------------
	// rom mapping
	// ----------------------------------------------------------
	always_comb begin
		case (kind_i)
			MBC_1:        masked_bank = {2'b00, (bank.mbc1_mode ? 2'b00 : bank.ram_bank[1:0]),
			                             bank.rom_bank[4:0]} & rom_mask_i;
			MBC_2, MBC_3: masked_bank = {2'b00, bank.rom_bank[6:0]} & rom_mask_i;
			default:      masked_bank = bank.rom_bank & rom_mask_i;  // mbc5 uses all 9 bits
		endcase

		if (kind_i == MBC_NONE) begin
			bank_field = {8'd0, cart_addr_i[14:13]};  // flat 32k
		end else if (cart_addr_i[15:14] == ROM_BANK0_AREA) begin
			bank_field = {9'd0, cart_addr_i[13]};
		end else if (cart_addr_i[15:14] == ROM_BANKN_AREA) begin
			bank_field = {masked_bank, cart_addr_i[13]};
		end else begin
			bank_field = '0;
		end
	end

	assign rom_addr_o = {bank_field, cart_addr_i[12:1]};  // byte lane picked by a0 outside

	// ----------------------------------------------------------
	// ram mapping
	// ----------------------------------------------------------
	always_comb begin
		case (kind_i)
			MBC_1:   ram_bank_sel = bank.mbc1_mode ? {2'b00, bank.ram_bank[1:0]} : '0;
			MBC_3:   ram_bank_sel = {2'b00, bank.ram_bank[1:0]};
			MBC_5:   ram_bank_sel = bank.ram_bank;
			default: ram_bank_sel = '0;  // mbc2 ram is internal, one bank
		endcase
	end

	assign cram_addr = {ram_bank_sel & ram_mask_i, cart_addr_i[12:0]};
	assign cram_sel  = (cart_addr_i[15:13] == CRAM_REGION);
	assign mbc2_win  = (kind_i == MBC_2) && (cart_addr_i[15:9] == MBC2_RAM_WIN);

	cart_ram i_cart_ram (
		.clk_sys (clk_sys),
		.we_i    (cart_wr_i && cram_sel),
		.addr_i  (cram_addr),
		.wdata_i (cart_di_i),
		.rdata_o (ram_q)
	);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cram_valid_o <= 1'b0;
		end else begin
			cram_valid_o <= cart_rd_i && cram_sel;  // same cycle as registered ram read
		end
	end

	always_ff @(posedge clk_sys) begin
		rd_en_q   <= bank.ram_enable;
		rd_mbc2_q <= mbc2_win;
		rd_rtc_q  <= bank.rtc_mode;
	end

	// disabled ram floats high, mbc2 has only a nibble, clock registers read zero
	assign cart_do_o = !rd_en_q  ? 8'hFF :
	                   rd_mbc2_q ? {4'hF, ram_q[3:0]} :
	                   rd_rtc_q  ? 8'h00 : ram_q;

endmodule

// File: hw/gb_cart_mapper.sv
`timescale 1ns/1ps

module gb_cart_mapper (
	input  logic                        clk_sys,
	input  logic                        reset,

	// rom download
	input  logic                        dl_active_i,
	input  logic                        dl_wr_i,
	input  gb_cart_pkg::dl_addr_t       dl_addr_i,
	input  gb_cart_pkg::dl_data_t       dl_data_i,

	// cpu cartridge bus
	input  logic                        cart_rd_i,
	input  logic                        cart_wr_i,
	input  gb_cart_pkg::cpu_addr_t      cart_addr_i,
	input  gb_cart_pkg::cpu_data_t      cart_di_i,

	output gb_cart_pkg::rom_word_addr_t rom_addr_o,   // to sdram
	output gb_cart_pkg::cpu_data_t      cart_do_o,    // cart ram read data
	output logic                        cram_valid_o,
	output logic                        cgb_game_o
);
	import gb_cart_pkg::*;

	mbc_kind_t kind;      // decoded header results
	rom_bank_t rom_mask;
	ram_bank_t ram_mask;

	mbc_bank_if bank_if ();

	cart_header_capture i_cart_header_capture (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.kind_o      (kind),
		.rom_mask_o  (rom_mask),
		.ram_mask_o  (ram_mask),
		.cgb_game_o  (cgb_game_o)
	);

	mbc_bank_regs i_mbc_bank_regs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.cart_wr_i   (cart_wr_i),
		.cart_addr_i (cart_addr_i),
		.cart_di_i   (cart_di_i),
		.kind_i      (kind),
		.bank        (bank_if.regs)
	);

	cart_addr_map i_cart_addr_map (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_rd_i    (cart_rd_i),
		.cart_wr_i    (cart_wr_i),
		.cart_addr_i  (cart_addr_i),
		.cart_di_i    (cart_di_i),
		.kind_i       (kind),
		.rom_mask_i   (rom_mask),
		.ram_mask_i   (ram_mask),
		.bank         (bank_if.map),
		.rom_addr_o   (rom_addr_o),
		.cart_do_o    (cart_do_o),
		.cram_valid_o (cram_valid_o)
	);

endmodule

// File: tests/gb_cart_mapper_chk.sv
`timescale 1ns/1ps

module gb_cart_mapper_chk (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        cart_rd_i,
	input  gb_cart_pkg::cpu_addr_t      cart_addr_i,
	input  gb_cart_pkg::rom_word_addr_t rom_addr_o,
	input  logic                        cram_valid_o
);
	import gb_cart_pkg::*;

	logic ram_rd;          // cpu read inside a000-bfff
	int   fail_count = 0;  // number of failed assertions

	assign ram_rd = cart_rd_i && (cart_addr_i[15:13] == CRAM_REGION);

	// ----------------------------------------------------------
	// read data valid, exactly one cycle after a ram read
	// ----------------------------------------------------------
	a_valid_after_read: assert property (@(posedge clk_sys) disable iff (reset)
		ram_rd |=> cram_valid_o)
		else begin
			$error("cram_valid_o did not follow a ram window read");
			fail_count++;
		end

	a_valid_only_after_read: assert property (@(posedge clk_sys) disable iff (reset)
		!ram_rd |=> !cram_valid_o)
		else begin
			$error("cram_valid_o high without a ram window read");
			fail_count++;
		end

	// register is cleared by the reset edge
	a_valid_low_in_reset: assert property (@(posedge clk_sys)
		reset |=> !cram_valid_o)
		else begin
			$error("cram_valid_o high during reset");
			fail_count++;
		end

	a_rom_addr_known: assert property (@(posedge clk_sys) disable iff (reset)
		!$isunknown(rom_addr_o))
		else begin
			$error("rom_addr_o has unknown bits");
			fail_count++;
		end

endmodule

bind gb_cart_mapper gb_cart_mapper_chk i_gb_cart_mapper_chk (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.cart_rd_i    (cart_rd_i),
	.cart_addr_i  (cart_addr_i),
	.rom_addr_o   (rom_addr_o),
	.cram_valid_o (cram_valid_o)
);

// File: tests/tb_gb_cart_mapper.sv
`timescale 1ns/1ps

module tb_gb_cart_mapper;
	import gb_cart_pkg::*;

	localparam int RESET_CYCLES = 4;
	localparam int N_STEPS      = 49;
	localparam int CYCLE_LIMIT  = 4 * N_STEPS + RESET_CYCLES;  // each step takes one cycle

	typedef enum logic [2:0] {
		OP_HDR,   // header word on the download bus, dl_active high
		OP_WR,    // cpu write with the table data
		OP_RAMW,  // cpu write of a random byte, kept in the model
		OP_RDM,   // ram read, expected byte from the model
		OP_RD,    // ram read, expected byte from the table
		OP_ROM,   // rom word address probe
		OP_FLAG   // colour game flag
	} op_e;

	typedef struct packed {
		op_e            op;
		dl_addr_t       addr;  // download or cpu address
		dl_data_t       data;
		rom_word_addr_t exp;
	} step_t;

	logic                clk_sys;
	logic                reset;
	logic                dl_active_i;
	logic                dl_wr_i;
	dl_addr_t            dl_addr_i;
	dl_data_t            dl_data_i;
	logic                cart_rd_i;
	logic                cart_wr_i;
	cpu_addr_t           cart_addr_i;
	cpu_data_t           cart_di_i;
	rom_word_addr_t      rom_addr_o;
	cpu_data_t           cart_do_o;
	logic                cram_valid_o;
	logic                cgb_game_o;

	cpu_data_t   model [8192];        // ram bytes by cart_addr[12:0], one bank in use
	logic [31:0] lfsr   = 32'ha62a2665;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;

	step_t steps [N_STEPS] = '{
		// mbc1 header, 64 banks, 4 ram banks, cgb only
		'{OP_HDR, 'h142, 'hC000, 'h0}, '{OP_HDR, 'h146, 'h0100, 'h0},
		'{OP_HDR, 'h148, 'h0305, 'h0}, '{OP_FLAG, 'h0, 'h0, 'h1},
		'{OP_ROM, 'h4000, 'h0, 'h002000},                // bank 1 after reset
		// mbc1 banking
		'{OP_WR, 'h2000, 'h05, 'h0}, '{OP_WR, 'h2000, 'h00, 'h0},
		'{OP_ROM, 'h4000, 'h0, 'h002000},                // 0 maps to 1
		'{OP_WR, 'h4000, 'h01, 'h0}, '{OP_WR, 'h2000, 'h25, 'h0},
		'{OP_ROM, 'h5678, 'h0, 'h04AB3C},                // {01,00101}
		'{OP_ROM, 'h1234, 'h0, 'h00091A},                // fixed bank 0
		'{OP_WR, 'h6000, 'h01, 'h0},
		'{OP_ROM, 'h5678, 'h0, 'h00AB3C},                // mode 1 drops upper bits
		'{OP_WR, 'h6000, 'h00, 'h0}, '{OP_WR, 'h4000, 'h03, 'h0},
		'{OP_ROM, 'h4000, 'h0, 'h04A000},                // 0x65 & 63
		// mbc5, 512 banks
		'{OP_HDR, 'h146, 'h1900, 'h0}, '{OP_HDR, 'h148, 'h0308, 'h0},
		'{OP_WR, 'h2000, 'h34, 'h0}, '{OP_WR, 'h3000, 'h01, 'h0},
		'{OP_ROM, 'h4000, 'h0, 'h268000}, '{OP_ROM, 'h6002, 'h0, 'h269001},
		// ram bank 2, random bytes
		'{OP_WR, 'h0000, 'h0A, 'h0}, '{OP_WR, 'h4000, 'h02, 'h0},
		'{OP_RAMW, 'hA000, 'h0, 'h0}, '{OP_RAMW, 'hA001, 'h0, 'h0},
		'{OP_RAMW, 'hABCD, 'h0, 'h0}, '{OP_RAMW, 'hBFFF, 'h0, 'h0},
		'{OP_RDM, 'hA000, 'h0, 'h0}, '{OP_RDM, 'hA001, 'h0, 'h0},  // back to back
		'{OP_RDM, 'hABCD, 'h0, 'h0}, '{OP_RDM, 'hBFFF, 'h0, 'h0},
		'{OP_RAMW, 'hB5A5, 'h0, 'h0}, '{OP_RDM, 'hB5A5, 'h0, 'h0},
		// read gating
		'{OP_WR, 'h0000, 'h00, 'h0}, '{OP_RD, 'hA000, 'h0, 'hFF},  // disabled
		'{OP_HDR, 'h146, 'h1000, 'h0}, '{OP_WR, 'h0000, 'h0A, 'h0},
		'{OP_WR, 'h4000, 'h08, 'h0}, '{OP_RD, 'hA000, 'h0, 'h00},  // mbc3 clock mode
		'{OP_HDR, 'h146, 'h0500, 'h0}, '{OP_WR, 'h0000, 'h0A, 'h0},
		'{OP_WR, 'hA010, 'h5A, 'h0}, '{OP_RD, 'hA010, 'h0, 'hFA},  // mbc2 nibble
		// a download resets the bank registers
		'{OP_WR, 'h2000, 'h05, 'h0}, '{OP_ROM, 'h4000, 'h0, 'h00A000},
		'{OP_HDR, 'h000, 'h0000, 'h0}, '{OP_ROM, 'h4000, 'h0, 'h002000}
	};

	gb_cart_mapper i_gb_cart_mapper (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active_i  (dl_active_i),
		.dl_wr_i      (dl_wr_i),
		.dl_addr_i    (dl_addr_i),
		.dl_data_i    (dl_data_i),
		.cart_rd_i    (cart_rd_i),
		.cart_wr_i    (cart_wr_i),
		.cart_addr_i  (cart_addr_i),
		.cart_di_i    (cart_di_i),
		.rom_addr_o   (rom_addr_o),
		.cart_do_o    (cart_do_o),
		.cram_valid_o (cram_valid_o),
		.cgb_game_o   (cgb_game_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;  // 25 mhz
	end

	// ----------------------------------------------------------
	// random bytes, galois lfsr x^32+x^22+x^2+x+1
	// ----------------------------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic random_byte(output cpu_data_t b);
		for (int k = 0; k < 8; k++) begin
			b    = {b[6:0], lfsr[0]};  // one step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic check_rom_addr(input string name, input rom_word_addr_t exp,
	                              input rom_word_addr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input cpu_data_t exp, input cpu_data_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// ----------------------------------------------------------
	// apply the table, one step per cycle
	// ----------------------------------------------------------
	initial begin
		step_t     st;
		cpu_data_t wdata;
		cpu_data_t rd_exp;
		logic      rd_pend;
		string     name;
		string     rd_name;
		reset       = 1'b1;
		dl_active_i = 1'b0;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = '0;
		cart_rd_i   = 1'b0;
		cart_wr_i   = 1'b0;
		cart_addr_i = '0;
		cart_di_i   = '0;
		rd_pend     = 1'b0;
		rd_exp      = '0;
		rd_name     = "";
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;
		for (int i = 0; i < N_STEPS; i++) begin
			st    = steps[i];
			name  = $sformatf("step%0d_%s", i, st.op.name());
			wdata = st.data[7:0];
			if (st.op == OP_RAMW) begin
				random_byte(wdata);
				model[st.addr[12:0]] = wdata;
			end
			@(posedge clk_sys);
			dl_active_i <= (st.op == OP_HDR);
			dl_wr_i     <= (st.op == OP_HDR);
			dl_addr_i   <= st.addr;
			dl_data_i   <= st.data;
			cart_rd_i   <= st.op inside {OP_RD, OP_RDM};
			cart_wr_i   <= st.op inside {OP_WR, OP_RAMW};
			cart_addr_i <= st.addr[15:0];
			cart_di_i   <= wdata;
			@(negedge clk_sys);
			check_flag({name, "_valid"}, rd_pend, cram_valid_o);  // previous step's read
			if (rd_pend) begin
				check_byte(rd_name, rd_exp, cart_do_o);
			end
			if (st.op == OP_ROM) begin
				check_rom_addr(name, st.exp, rom_addr_o);  // combinational path
			end
			if (st.op == OP_FLAG) begin
				check_flag(name, st.exp[0], cgb_game_o);
			end
			rd_pend = st.op inside {OP_RD, OP_RDM};
			rd_exp  = (st.op == OP_RDM) ? model[st.addr[12:0]] : st.exp[7:0];
			rd_name = name;
		end
		@(negedge clk_sys);  // drain a read from the last step
		if (rd_pend) begin
			check_byte(rd_name, rd_exp, cart_do_o);
		end
		errors += i_gb_cart_mapper.i_gb_cart_mapper_chk.fail_count;  // bound assertions
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: table not finished after %0d cycles", CYCLE_LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

// File: sources.f
hw/gb_cart_pkg.sv
hw/mbc_bank_if.sv
hw/cart_header_capture.sv
hw/mbc_bank_regs.sv
hw/cart_ram.sv
hw/cart_addr_map.sv
hw/gb_cart_mapper.sv
tests/gb_cart_mapper_chk.sv
tests/tb_gb_cart_mapper.sv

// File: Bender.yml
package:
  name: gb_cart_mapper

sources:
  - files:
      - hw/gb_cart_pkg.sv
      - hw/mbc_bank_if.sv
      - hw/cart_header_capture.sv
      - hw/mbc_bank_regs.sv
      - hw/cart_ram.sv
      - hw/cart_addr_map.sv
      - hw/gb_cart_mapper.sv
  - target: test
    files:
      - tests/gb_cart_mapper_chk.sv
      - tests/tb_gb_cart_mapper.sv
